/* inflight_counter.sv */
//----------------------------------------------------------------------
// counts requests issued to the network and not yet answered, and
// flags when the outstanding count has reached the limit
//----------------------------------------------------------------------

`include "proc_net_adapter_params.svh"

module inflight_counter
#(
  parameter int max_requests = `MAX_REQUESTS
)(
  input  logic clk,
  input  logic rst,
  input  logic issue,
  input  logic retire,
  output logic at_limit
);

  localparam int               cnt_w = $clog2(max_requests + 1);
  localparam logic [cnt_w-1:0] limit = cnt_w'(max_requests);

  logic [cnt_w-1:0] count;            // outstanding requests

  // the encoder holds issue low at the limit
  always_ff @(posedge clk)
  begin
    if (rst)
      count <= '0;
    else if (issue && !retire)
      count <= count + 1'b1;
    else if (retire && !issue)
      count <= count - 1'b1;
  end

  assign at_limit = (count == limit);

endmodule

/* msg_queue.sv */
//----------------------------------------------------------------------
// two-entry valid/ready queue; payload type set per instance, holds a
// full-rate stream without bubbles
//----------------------------------------------------------------------

module msg_queue
#(
  parameter type msg_t = logic [31:0]
)(
  input  logic clk,
  input  logic rst,
  input  logic enq_val,
  output logic enq_rdy,
  input  msg_t enq_msg,
  output logic deq_val,
  input  logic deq_rdy,
  output msg_t deq_msg
);

  msg_t       entry [2];              // payload storage
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;                  // 0, 1 or 2 entries
  logic       do_enq;
  logic       do_deq;

  assign do_enq = enq_val && enq_rdy;
  assign do_deq = deq_val && deq_rdy;

  assign enq_rdy = (count != 2'd2);   // drops only when both full
  assign deq_val = (count != 2'd0);
  assign deq_msg = entry[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (do_enq)
      entry[wr_ptr] <= enq_msg;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end
    else
    begin
      if (do_enq)
        wr_ptr <= ~wr_ptr;
      if (do_deq)
        rd_ptr <= ~rd_ptr;
      case ({do_enq, do_deq})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;      // idle or enq and deq together
      endcase
    end
  end

endmodule

/* proc_net_adapter.f */
+incdir+.
proc_net_adapter_pkg.sv
msg_queue.sv
inflight_counter.sv
req_encoder.sv
resp_decoder.sv
proc_net_adapter.sv
proc_net_adapter_props.sv
proc_net_adapter_tb.sv

/* proc_net_adapter.sv */
//----------------------------------------------------------------------
// processor-to-network memory adapter for one router node; connect
// the processor to memreq/memresp and the router to netin/netout
//----------------------------------------------------------------------

`include "proc_net_adapter_params.svh"

module proc_net_adapter
#(
  parameter proc_net_adapter_pkg::node_id_t router_id    = `ROUTER_ID,
  parameter int                             max_requests = `MAX_REQUESTS
)(
  input  logic                            clk,
  input  logic                            rst,

  // processor request port
  input  logic                            memreq_val,
  output logic                            memreq_rdy,
  input  proc_net_adapter_pkg::mem_req_t  memreq_msg,

  // into the network
  output logic                            netin_val,
  input  logic                            netin_rdy,
  output proc_net_adapter_pkg::net_req_t  netin_msg,

  // out of the network
  input  logic                            netout_val,
  output logic                            netout_rdy,
  input  proc_net_adapter_pkg::net_resp_t netout_msg,

  // processor response port
  output logic                            memresp_val,
  input  logic                            memresp_rdy,
  output proc_net_adapter_pkg::mem_resp_t memresp_msg
);

  logic at_limit;                     // counter full, stall requests
  logic issue;                        // request accepted
  logic retire;                       // response delivered

  //--------------------------------------------------------------------
  // request path
  //--------------------------------------------------------------------

  req_encoder #(.router_id(router_id)) u_req_encoder
  (
    .clk        (clk),
    .rst        (rst),
    .memreq_val (memreq_val),
    .memreq_rdy (memreq_rdy),
    .memreq_msg (memreq_msg),
    .at_limit   (at_limit),
    .issue      (issue),
    .netin_val  (netin_val),
    .netin_rdy  (netin_rdy),
    .netin_msg  (netin_msg)
  );

  //--------------------------------------------------------------------
  // response path and in-flight tracking
  //--------------------------------------------------------------------

  resp_decoder u_resp_decoder
  (
    .clk         (clk),
    .rst         (rst),
    .netout_val  (netout_val),
    .netout_rdy  (netout_rdy),
    .netout_msg  (netout_msg),
    .memresp_val (memresp_val),
    .memresp_rdy (memresp_rdy),
    .memresp_msg (memresp_msg),
    .retire      (retire)
  );

  inflight_counter #(.max_requests(max_requests)) u_inflight_counter
  (
    .clk      (clk),
    .rst      (rst),
    .issue    (issue),
    .retire   (retire),
    .at_limit (at_limit)
  );

endmodule

/* proc_net_adapter_params.svh */
//----------------------------------------------------------------------
// build settings for the processor/network memory adapter, included
// by the package and by modules that take their defaults from here
//----------------------------------------------------------------------

`ifndef PROC_NET_ADAPTER_PARAMS_SVH
`define PROC_NET_ADAPTER_PARAMS_SVH

// network shape
`define NUM_NODES     4     // nodes reachable through the router
`define ROUTER_ID     1     // node this adapter sits on

// memory message widths
`define ADDR_W        16    // byte address
`define DATA_W        32    // one word of data

// lowest address bit of the destination node field, so consecutive
// words are spread across the nodes
`define DEST_OFFSET   2

// flow control
`define MAX_REQUESTS  16    // requests allowed in flight

`endif

/* proc_net_adapter_pkg.sv */
//----------------------------------------------------------------------
// message formats of the adapter, shared by the RTL and the testbench;
// import it where the structs or encodings are needed
//----------------------------------------------------------------------

`include "proc_net_adapter_params.svh"

package proc_net_adapter_pkg;

  localparam int node_w = $clog2(`NUM_NODES);   // src/dest field width

  typedef logic [node_w-1:0]  node_id_t;
  typedef logic [`ADDR_W-1:0] mem_addr_t;
  typedef logic [`DATA_W-1:0] mem_data_t;

  //--------------------------------------------------------------------
  // encodings
  //--------------------------------------------------------------------

  // same code used in requests and in their responses
  typedef enum logic
  {
    mem_read  = 1'b0,
    mem_write = 1'b1
  } mem_type_t;

  typedef logic [1:0] mem_len_t;

  localparam mem_len_t len_word = 2'd0;   // full 4 bytes
  localparam mem_len_t len_byte = 2'd1;   // low byte, zero-extended
  localparam mem_len_t len_half = 2'd2;   // low halfword, zero-extended

  //--------------------------------------------------------------------
  // message structs, msb first
  //--------------------------------------------------------------------

  typedef struct packed {
    mem_type_t mtype;
    mem_addr_t addr;
    mem_len_t  len;
    mem_data_t data;
  } mem_req_t;                            // 51 bits

  typedef struct packed {
    mem_type_t mtype;
    mem_len_t  len;
    mem_data_t data;                      // zero on write responses
  } mem_resp_t;                           // 35 bits

  typedef struct packed {
    node_id_t  dest;
    node_id_t  src;
    mem_req_t  payload;
  } net_req_t;                            // 55 bits

  typedef struct packed {
    node_id_t  dest;
    node_id_t  src;
    mem_resp_t payload;
  } net_resp_t;                           // 39 bits

endpackage

/* proc_net_adapter_props.sv */
//----------------------------------------------------------------------
// handshake and in-flight limit assertions, bound into the adapter top
//----------------------------------------------------------------------

`include "proc_net_adapter_params.svh"

module proc_net_adapter_props
#(
  parameter int max_requests = `MAX_REQUESTS
)(
  input logic                            clk,
  input logic                            rst,
  input logic                            memreq_val,
  input logic                            memreq_rdy,
  input proc_net_adapter_pkg::mem_req_t  memreq_msg,
  input logic                            netin_val,
  input logic                            netin_rdy,
  input proc_net_adapter_pkg::net_req_t  netin_msg,
  input logic                            memresp_val,
  input logic                            memresp_rdy,
  input proc_net_adapter_pkg::mem_resp_t memresp_msg,
  input logic                            at_limit
);

  timeunit 1ns;
  timeprecision 1ps;

  int assert_fails = 0;               // read by the testbench at the end
  int outstanding;                    // memreq taken, memresp not yet

  task automatic note_fail(input string what);
    $error("%s", what);
    assert_fails++;
  endtask

  // port-level view of the in-flight count
  always_ff @(posedge clk)
  begin
    if (rst)
      outstanding <= 0;
    else
      outstanding <= outstanding + int'(memreq_val && memreq_rdy)
                     - int'(memresp_val && memresp_rdy);
  end

  //--------------------------------------------------------------------
  // valid and payload held until the transfer
  //--------------------------------------------------------------------

  a_memreq_hold: assert property (@(posedge clk) disable iff (rst)
    memreq_val && !memreq_rdy |=> memreq_val && $stable(memreq_msg))
    else note_fail("memreq valid or payload changed before transfer");

  a_netin_hold: assert property (@(posedge clk) disable iff (rst)
    netin_val && !netin_rdy |=> netin_val && $stable(netin_msg))
    else note_fail("netin valid or payload changed before transfer");

  a_memresp_hold: assert property (@(posedge clk) disable iff (rst)
    memresp_val && !memresp_rdy |=> memresp_val && $stable(memresp_msg))
    else note_fail("memresp valid or payload changed before transfer");

  // flag tracks the requests seen on the ports
  a_limit_flag: assert property (@(posedge clk) disable iff (rst)
    at_limit == (outstanding == max_requests))
    else note_fail("at_limit does not match the outstanding request count");

  // no new request once the counter is full
  a_no_issue_at_limit: assert property (@(posedge clk) disable iff (rst)
    memreq_val && memreq_rdy |-> outstanding < max_requests)
    else note_fail("memreq accepted while at the in-flight limit");

  a_idle_after_rst: assert property (@(posedge clk)
    rst |=> !netin_val && !memresp_val)
    else note_fail("valid high on an output right after reset");

endmodule

bind proc_net_adapter proc_net_adapter_props #(.max_requests(max_requests)) u_props (.*);

/* proc_net_adapter_tb.sv */
//----------------------------------------------------------------------
// testbench for the memory adapter: network memory model on netin and
// netout, reference model of the expected messages, directed and random traffic
//----------------------------------------------------------------------

`include "proc_net_adapter_params.svh"

module proc_net_adapter_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import proc_net_adapter_pkg::*;

  localparam int       max_req    = 4;
  localparam node_id_t node_id    = 2'd1;
  localparam int       num_random = 40;
  localparam int       num_reqs   = 21 + num_random;  // directed plus random

  logic      clk = 1'b0;
  logic      rst;
  logic      memreq_val;
  logic      memreq_rdy;
  mem_req_t  memreq_msg;
  logic      netin_val;
  logic      netin_rdy;
  net_req_t  netin_msg;
  logic      netout_val;
  logic      netout_rdy;
  net_resp_t netout_msg;
  logic      memresp_val;
  logic      memresp_rdy;
  mem_resp_t memresp_msg;

  logic [7:0] ref_mem [0:65535];      // reference view of memory
  logic [7:0] net_mem [0:65535];      // memory behind the network
  net_req_t   exp_netin_q [$];
  mem_resp_t  exp_resp_q [$];
  net_resp_t  net_resp_q [$];         // waiting to go out on netout
  int         issued;
  int         received;
  int         value_errs;
  int         other_errs;
  logic       stall_on;               // random back-pressure enable
  logic       hold_resp;              // network keeps its responses

  proc_net_adapter #(.router_id(node_id), .max_requests(max_req)) u_proc_net_adapter (.*);

  always #20 clk = ~clk;

  //--------------------------------------------------------------------
  // reference model
  //--------------------------------------------------------------------

  function automatic int len_bytes(mem_len_t len);
    case (len)
      len_byte: return 1;
      len_half: return 2;
      default:  return 4;
    endcase
  endfunction

  function automatic net_req_t ref_netin(mem_req_t req);
    net_req_t nr;
    nr.dest    = req.addr[3:2];       // node field above the byte offset
    nr.src     = node_id;
    nr.payload = req;
    return nr;
  endfunction

  function automatic mem_resp_t ref_resp(mem_req_t req);
    mem_resp_t r;
    r.mtype = req.mtype;
    r.len   = req.len;
    r.data  = '0;                     // writes answer with zero data
    if (req.mtype == mem_read)
      for (int i = 0; i < len_bytes(req.len); i++)
        r.data[8*i +: 8] = ref_mem[req.addr + i];   // little-endian, zero-extended
    return r;
  endfunction

  task automatic ref_write(input mem_req_t req);
    if (req.mtype == mem_write)
      for (int i = 0; i < len_bytes(req.len); i++)
        ref_mem[req.addr + i] = req.data[8*i +: 8];
  endtask

  // memory node on the far side of the router
  task automatic net_access(input net_req_t nr, output net_resp_t rsp);
    rsp.dest          = nr.src;       // answer goes back to the sender
    rsp.src           = nr.dest;
    rsp.payload.mtype = nr.payload.mtype;
    rsp.payload.len   = nr.payload.len;
    rsp.payload.data  = '0;
    for (int i = 0; i < len_bytes(nr.payload.len); i++)
      if (nr.payload.mtype == mem_write)
        net_mem[nr.payload.addr + i] = nr.payload.data[8*i +: 8];
      else
        rsp.payload.data[8*i +: 8] = net_mem[nr.payload.addr + i];
  endtask

  task automatic log_mismatch(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
    $display("[ERROR] %s: got %h, expected %h at %0t", name, got, exp, $time);
    value_errs++;
  endtask

  task automatic log_failure(input string what);
    $display("error at %0t: %s", $time, what);
    other_errs++;
  endtask

  // called and returns at 2 ns after a rising edge
  task automatic send_req(input mem_type_t t, input logic [15:0] a, input mem_len_t l,
                          input logic [31:0] d);
    memreq_msg.mtype = t;
    memreq_msg.addr  = a;
    memreq_msg.len   = l;
    memreq_msg.data  = d;
    memreq_val       = 1'b1;
    do @(negedge clk); while (!memreq_rdy);
    @(posedge clk);
    #2;
    memreq_val = 1'b0;
  endtask

  task automatic wait_drained();
    do
    begin
      @(posedge clk);
      #2;
    end
    while (issued != received);
  endtask

  //--------------------------------------------------------------------
  // comparing process, samples mid-cycle where all ports are stable
  //--------------------------------------------------------------------

  always @(negedge clk)
  begin
    if (!rst)
    begin
      if (memreq_val && memreq_rdy)
      begin
        exp_netin_q.push_back(ref_netin(memreq_msg));
        exp_resp_q.push_back(ref_resp(memreq_msg));
        ref_write(memreq_msg);
        issued++;
      end
      if (netin_val && netin_rdy)
      begin
        if (exp_netin_q.size() == 0)
          log_failure("netin transfer with no request outstanding");
        else if (netin_msg !== exp_netin_q[0])
          log_mismatch("netin_msg", netin_msg, exp_netin_q[0]);
        if (exp_netin_q.size() != 0)
          void'(exp_netin_q.pop_front());
      end
      if (memresp_val && memresp_rdy)
      begin
        if (exp_resp_q.size() == 0)
          log_failure("memresp transfer with no response expected");
        else if (memresp_msg !== exp_resp_q[0])
          log_mismatch("memresp_msg", memresp_msg, exp_resp_q[0]);
        if (exp_resp_q.size() != 0)
          void'(exp_resp_q.pop_front());
        received++;
      end
      if (issued - received > max_req)
        log_failure("more requests in flight than the limit allows");
    end
  end

  //--------------------------------------------------------------------
  // network side and processor response sink
  //--------------------------------------------------------------------

  always
  begin : network
    net_req_t  nreq;
    net_resp_t nrsp;
    logic      took_in;
    logic      gave_out;
    @(negedge clk);
    took_in  = netin_val && netin_rdy;  // completes at the next edge
    gave_out = netout_val && netout_rdy;
    nreq     = netin_msg;
    @(posedge clk);
    #2;
    if (took_in)
    begin
      net_access(nreq, nrsp);
      net_resp_q.push_back(nrsp);
    end
    if (gave_out)
    begin
      void'(net_resp_q.pop_front());
      netout_val = 1'b0;
    end
    netin_rdy   = stall_on ? ($urandom_range(3) != 0) : 1'b1;
    memresp_rdy = stall_on ? ($urandom_range(3) != 0) : 1'b1;
    if (!netout_val && net_resp_q.size() != 0 && !hold_resp &&
        (!stall_on || $urandom_range(2) != 0))
    begin
      netout_val = 1'b1;              // held until taken
      netout_msg = net_resp_q[0];
    end
  end

  initial
  begin
    repeat (400 * num_reqs) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", 400 * num_reqs);
    $display("RESULT: FAIL");
    $finish;
  end

  //--------------------------------------------------------------------
  // test sequence
  //--------------------------------------------------------------------

  initial
  begin
    mem_len_t    rlen;
    logic [15:0] raddr;
    void'($urandom(12427));
    {issued, received, value_errs, other_errs} = '0;
    {stall_on, hold_resp, memreq_val, netout_val} = '0;
    memreq_msg  = '0;
    netout_msg  = '0;
    netin_rdy   = 1'b1;
    memresp_rdy = 1'b1;
    for (int a = 0; a < 65536; a++)
    begin
      ref_mem[a] = 8'(a ^ (a >> 8) ^ 8'h3c);
      net_mem[a] = ref_mem[a];
    end
    rst = 1'b1;
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;
    @(negedge clk);
    if (netin_val || memresp_val || !memreq_rdy || !netout_rdy)
      log_failure("port valid/ready levels wrong after reset");
    @(posedge clk);
    #2;

    // words, then bytes over a known word, then halfwords
    send_req(mem_write, 16'h0000, len_word, 32'hdead_beef);
    send_req(mem_write, 16'h0004, len_word, 32'h1234_5678);
    send_req(mem_read,  16'h0000, len_word, '0);
    send_req(mem_read,  16'h0004, len_word, '0);
    send_req(mem_write, 16'h0008, len_word, 32'h4433_2211);
    send_req(mem_write, 16'h0008, len_byte, 32'h0000_00a5);
    for (int i = 8; i < 12; i++)
      send_req(mem_read, 16'(i), len_byte, '0);
    send_req(mem_write, 16'h000c, len_half, 32'h0000_beef);
    send_req(mem_write, 16'h000e, len_half, 32'h0000_cafe);
    send_req(mem_read,  16'h000c, len_half, '0);
    send_req(mem_read,  16'h000e, len_half, '0);
    send_req(mem_read,  16'h000c, len_word, '0);

    // network sits on its responses, adapter must stop at the limit
    wait_drained();
    hold_resp = 1'b1;
    fork
      for (int i = 0; i < 6; i++)
        send_req(mem_read, 16'(4 * i), len_word, '0);
      begin
        do @(posedge clk); while (issued - received < max_req);
        repeat (10) @(posedge clk);
        @(negedge clk);
        if (issued - received != max_req || memreq_rdy)
          log_failure("memreq not held off at the in-flight limit");
        @(posedge clk);
        #2;
        hold_resp = 1'b0;
      end
    join

    // random traffic under random back-pressure
    stall_on = 1'b1;
    for (int n = 0; n < num_random; n++)
    begin
      rlen  = mem_len_t'($urandom_range(2));
      raddr = 16'($urandom_range(255)) & ~(16'(len_bytes(rlen)) - 16'd1);  // aligned
      send_req(mem_type_t'($urandom_range(1)), raddr, rlen, $urandom);
      repeat ($urandom_range(3))
      begin
        @(posedge clk);
        #2;
      end
    end
    wait_drained();
    stall_on = 1'b0;
    repeat (4) @(posedge clk);

    if (issued != num_reqs || received != issued)
      log_failure($sformatf("issued %0d requests, received %0d responses", issued, received));
    if (exp_netin_q.size() != 0 || exp_resp_q.size() != 0 || net_resp_q.size() != 0)
      log_failure("messages left over at the end of the run");
    $display("errors: %0d wrong values, %0d other failures, %0d assertion failures",
             value_errs, other_errs, u_proc_net_adapter.u_props.assert_fails);
    if (value_errs == 0 && other_errs == 0 && u_proc_net_adapter.u_props.assert_fails == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* req_encoder.sv */
//----------------------------------------------------------------------
// request path: adds the network header to each memory request and
// queues it for the network, holding off the processor at the limit
//----------------------------------------------------------------------

`include "proc_net_adapter_params.svh"

module req_encoder
#(
  parameter proc_net_adapter_pkg::node_id_t router_id = `ROUTER_ID
)(
  input  logic                           clk,
  input  logic                           rst,

  input  logic                           memreq_val,
  output logic                           memreq_rdy,
  input  proc_net_adapter_pkg::mem_req_t memreq_msg,

  input  logic                           at_limit,
  output logic                           issue,

  output logic                           netin_val,
  input  logic                           netin_rdy,
  output proc_net_adapter_pkg::net_req_t netin_msg
);

  import proc_net_adapter_pkg::*;

  net_req_t net_req;                  // header plus original request
  logic     q_enq_val;
  logic     q_enq_rdy;

  //--------------------------------------------------------------------
  // header build
  //--------------------------------------------------------------------

  always_comb
  begin
    // word-interleaved: node picked by the bits above the byte offset
    net_req.dest    = memreq_msg.addr[`DEST_OFFSET +: node_w];
    net_req.src     = router_id;      // responses come back here
    net_req.payload = memreq_msg;
  end

  // limit gates both sides, so the queue only sees issued requests
  assign q_enq_val  = memreq_val && !at_limit;
  assign memreq_rdy = q_enq_rdy && !at_limit;
  assign issue      = memreq_val && memreq_rdy;

  //--------------------------------------------------------------------
  // output queue toward the network
  //--------------------------------------------------------------------

  msg_queue #(.msg_t(net_req_t)) u_req_q
  (
    .clk     (clk),
    .rst     (rst),
    .enq_val (q_enq_val),
    .enq_rdy (q_enq_rdy),
    .enq_msg (net_req),
    .deq_val (netin_val),
    .deq_rdy (netin_rdy),
    .deq_msg (netin_msg)
  );

endmodule

/* resp_decoder.sv */
//----------------------------------------------------------------------
// response path: takes network responses, drops src/dest and queues
// the memory response for the processor
//----------------------------------------------------------------------

module resp_decoder
(
  input  logic                            clk,
  input  logic                            rst,

  input  logic                            netout_val,
  output logic                            netout_rdy,
  input  proc_net_adapter_pkg::net_resp_t netout_msg,

  output logic                            memresp_val,
  input  logic                            memresp_rdy,
  output proc_net_adapter_pkg::mem_resp_t memresp_msg,

  output logic                            retire
);

  import proc_net_adapter_pkg::*;

  mem_resp_t mem_resp;                // header stripped

  // routing already delivered it here, header carries nothing more
  assign mem_resp = netout_msg.payload;

  msg_queue #(.msg_t(mem_resp_t)) u_resp_q
  (
    .clk     (clk),
    .rst     (rst),
    .enq_val (netout_val),
    .enq_rdy (netout_rdy),
    .enq_msg (mem_resp),
    .deq_val (memresp_val),
    .deq_rdy (memresp_rdy),
    .deq_msg (memresp_msg)
  );

  // a request counts as done once the processor takes its response
  assign retire = memresp_val && memresp_rdy;

endmodule
